/* Makefile */
TOP = decode_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f project.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -F -q "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/decode_tb.sv */
`timescale 1ns/100ps

module decode_tb;
    import decode_pkg::*;

    typedef enum int {
        k_add, k_sub, k_and, k_or, k_xor, k_nor, k_slt, k_sltu, k_sll, k_srl, k_sra,
        k_slli, k_srli, k_srai,
        k_addi, k_slti, k_sltui, k_andi, k_ori, k_xori,
        k_lu12i, k_pcaddu12i,
        k_ldb, k_ldbu, k_ldw, k_stb, k_stw,
        k_jirl, k_b, k_bl, k_beq, k_bne, k_blt, k_bge,
        k_break, k_bad
    } kind_e;

    localparam int num_kinds = int'(k_bad) + 1;

    logic        clk = 1'b0;
    logic        reset;
    logic        flush;
    logic        in_valid;
    logic        in_ready;
    fetch_t      in_item;
    logic        out_valid;
    logic        out_ready;
    ctrl_t       out_ctrl;
    logic        wb_en;
    logic [4:0]  wb_index;
    logic [31:0] wb_data;

    integer      stim_seed = 32'hadcb_45cd;
    integer      stall_seed = 32'hadcb_45cd;
    kind_e       in_kind;            // kind of the word on in_item
    logic [31:0] next_pc;
    logic [31:0] model [32];         // copy of the register file
    ctrl_t       exp_q [$];
    ctrl_t       exp_item;
    int          ready_mode;         // 0 always ready, 1 random stalls, 2 held low

    always #20 clk = ~clk;

    decode_top #(.lanes(num_lanes_default)) u_decode_top (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_item   (in_item),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_ctrl  (out_ctrl),
        .wb_en     (wb_en),
        .wb_index  (wb_index),
        .wb_data   (wb_data)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    // random fields with the opcode bits forced per kind
    function automatic logic [31:0] make_word(input kind_e kind, input logic [31:0] rnd);
        logic [31:0] w;
        w = rnd;
        case (kind)
            k_add:       w[31:15] = 17'h00020;
            k_sub:       w[31:15] = 17'h00022;
            k_slt:       w[31:15] = 17'h00024;
            k_sltu:      w[31:15] = 17'h00025;
            k_nor:       w[31:15] = 17'h00028;
            k_and:       w[31:15] = 17'h00029;
            k_or:        w[31:15] = 17'h0002a;
            k_xor:       w[31:15] = 17'h0002b;
            k_sll:       w[31:15] = 17'h0002e;
            k_srl:       w[31:15] = 17'h0002f;
            k_sra:       w[31:15] = 17'h00030;
            k_slli:      w[31:15] = 17'h00081;
            k_srli:      w[31:15] = 17'h00089;
            k_srai:      w[31:15] = 17'h00091;
            k_break:     w[31:15] = 17'h00054;
            k_slti:      w[31:22] = 10'h008;
            k_sltui:     w[31:22] = 10'h009;
            k_addi:      w[31:22] = 10'h00a;
            k_andi:      w[31:22] = 10'h00d;
            k_ori:       w[31:22] = 10'h00e;
            k_xori:      w[31:22] = 10'h00f;
            k_ldb:       w[31:22] = 10'h0a0;
            k_ldw:       w[31:22] = 10'h0a2;
            k_stb:       w[31:22] = 10'h0a4;
            k_stw:       w[31:22] = 10'h0a6;
            k_ldbu:      w[31:22] = 10'h0a8;
            k_jirl:      w[31:26] = 6'h13;
            k_b:         w[31:26] = 6'h14;
            k_bl:        w[31:26] = 6'h15;
            k_beq:       w[31:26] = 6'h16;
            k_bne:       w[31:26] = 6'h17;
            k_blt:       w[31:26] = 6'h18;
            k_bge:       w[31:26] = 6'h19;
            k_lu12i:     w[31:25] = 7'h0a;
            k_pcaddu12i: w[31:25] = 7'h0e;
            default:     w[31:26] = 6'h3f;  // no supported format uses this
        endcase
        return w;
    endfunction

    // reference decode keyed by the kind the word was built from
    function automatic ctrl_t expected_ctrl(input kind_e kind, input fetch_t f);
        ctrl_t       c;
        logic [31:0] w;
        logic [25:0] offs26;
        w      = f.inst;
        offs26 = {w[9:0], w[25:10]};
        c            = '0;
        c.inst_valid = 1'b1;
        c.wreg_en    = 1'b1;
        c.wreg_index = w[4:0];
        c.rd1_index  = w[9:5];
        c.rd2_index  = w[14:10];
        c.pc         = f.pc;
        c.inst       = f.inst;
        case (kind)
            k_sub:                c.alu_op = alu_sub;
            k_and, k_andi:        c.alu_op = alu_and;
            k_or, k_ori:          c.alu_op = alu_or;
            k_xor, k_xori:        c.alu_op = alu_xor;
            k_nor:                c.alu_op = alu_nor;
            k_slt, k_slti:        c.alu_op = alu_slt;
            k_sltu, k_sltui:      c.alu_op = alu_sltu;
            k_sll, k_slli:        c.alu_op = alu_sll;
            k_srl, k_srli:        c.alu_op = alu_srl;
            k_sra, k_srai:        c.alu_op = alu_sra;
            k_lu12i:              c.alu_op = alu_lui;
            default:              c.alu_op = alu_add;
        endcase
        if (kind inside {k_slli, k_srli, k_srai}) begin
            c.src2_sel = src_imm;
            c.imm      = {27'd0, w[14:10]};  // shift amount
        end
        if (kind inside {k_addi, k_slti, k_sltui, k_ldb, k_ldbu, k_ldw, k_stb, k_stw}) begin
            c.src2_sel = src_imm;
            c.imm      = {{20{w[21]}}, w[21:10]};
        end
        if (kind inside {k_andi, k_ori, k_xori}) begin
            c.src2_sel = src_imm;
            c.imm      = {20'd0, w[21:10]};
        end
        if (kind inside {k_lu12i, k_pcaddu12i}) begin
            c.src1_sel = (kind == k_lu12i) ? src_imm : src_pc;
            c.src2_sel = src_imm;
            c.imm      = {w[24:5], 12'd0};
        end
        if (kind inside {k_ldb, k_ldbu, k_ldw, k_stb, k_stw}) begin
            c.mem_op.is_mem       = 1'b1;
            c.mem_op.is_store     = kind inside {k_stb, k_stw};
            c.mem_op.size         = (kind inside {k_ldw, k_stw}) ? mem_word : mem_byte;
            c.mem_op.unsigned_ext = (kind == k_ldbu);
        end
        if (kind inside {k_jirl, k_b, k_bl, k_beq, k_bne, k_blt, k_bge}) begin
            c.src1_sel = (kind == k_jirl) ? src_reg : src_pc;  // jirl jumps off rj
            c.src2_sel = src_imm;
            c.imm      = {{14{w[25]}}, w[25:10], 2'b00};
        end
        case (kind)
            k_jirl:   c.branch_op = br_jirl;
            k_b, k_bl: c.branch_op = br_b;
            k_beq:    c.branch_op = br_beq;
            k_bne:    c.branch_op = br_bne;
            k_blt:    c.branch_op = br_blt;
            k_bge:    c.branch_op = br_bge;
            default:  c.branch_op = br_none;
        endcase
        if (kind inside {k_b, k_bl}) begin
            c.imm = {{4{offs26[25]}}, offs26, 2'b00};
        end
        if (kind == k_bl) begin
            c.wreg_index = 5'd1;
        end
        if (kind inside {k_stb, k_stw, k_beq, k_bne, k_blt, k_bge}) begin
            c.rd2_index = w[4:0];  // store data or compare operand
            c.wreg_en   = 1'b0;
        end
        if (kind inside {k_b, k_break, k_bad}) begin
            c.wreg_en = 1'b0;
        end
        c.is_break   = (kind == k_break);
        c.inst_valid = (kind != k_bad);
        c.rd1_data   = model[c.rd1_index];
        c.rd2_data   = model[c.rd2_index];
        return c;
    endfunction

    // scoreboard sampled on the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (flush) begin
                exp_q.delete();
            end else begin
                if (out_valid && out_ready) begin
                    assert (exp_q.size() != 0)
                        else abort_run("an output came out while nothing was outstanding");
                    exp_item = exp_q.pop_front();
                    assert (out_ctrl == exp_item)
                        else abort_run($sformatf("[FAIL] %0t: pc %h got %h expected %h",
                                                 $time, exp_item.pc, out_ctrl, exp_item));
                end
                if (in_valid && in_ready) begin
                    exp_q.push_back(expected_ctrl(in_kind, in_item));
                end
            end
        end
    end

    // output must hold while stalled
    assert property (@(posedge clk) disable iff (reset || flush)
        out_valid && !out_ready |=> out_valid && $stable(out_ctrl))
        else abort_run("the output changed while it was stalled");

    always @(negedge clk) begin
        integer r;
        r = $random(stall_seed);
        case (ready_mode)
            1:       out_ready = (r[1:0] != 2'b00);  // stall about one cycle in four
            2:       out_ready = 1'b0;
            default: out_ready = 1'b1;
        endcase
    end

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;
    endtask

    task automatic preload_regs();
        model[0] = 32'd0;
        for (int i = 0; i < 32; i++) begin  // the write to r0 must be dropped
            @(negedge clk);
            wb_en    = 1'b1;
            wb_index = 5'(i);
            wb_data  = $random(stim_seed);
            if (i != 0) begin
                model[i] = wb_data;
            end
        end
        @(negedge clk);
        wb_en = 1'b0;
    endtask

    task automatic send_item(input kind_e kind, input logic [31:0] word);
        int waited;
        @(negedge clk);
        in_valid     = 1'b1;
        in_kind      = kind;
        in_item.pc   = next_pc;
        in_item.inst = word;
        next_pc      = next_pc + 32'd4;
        waited       = 0;
        @(posedge clk);
        while (!in_ready) begin
            waited = waited + 1;
            if (waited > 200) begin
                abort_run("the decoder stopped accepting input words");
            end
            @(posedge clk);
        end
    endtask

    task automatic send_random(input int count);
        integer r;
        kind_e  kind;
        for (int n = 0; n < count; n++) begin
            r    = $random(stim_seed);
            kind = kind_e'(r[30:0] % num_kinds);
            send_item(kind, make_word(kind, $random(stim_seed)));
        end
    endtask

    task automatic idle_input();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            waited = waited + 1;
            if (waited > 2000) begin
                abort_run("decoded words never came out of the decoder");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        logic [31:0] w;
        reset      = 1'b1;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_item    = '0;
        in_kind    = k_add;
        out_ready  = 1'b1;
        wb_en      = 1'b0;
        wb_index   = 5'd0;
        wb_data    = 32'd0;
        ready_mode = 0;
        next_pc    = 32'h1c00_0000;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (!out_valid && in_ready)
            else abort_run("the decoder is not idle and ready after reset");

        preload_regs();

        // one word of every kind and then an add reading r0 twice
        for (int k = 0; k < num_kinds; k++) begin
            send_item(kind_e'(k), make_word(kind_e'(k), $random(stim_seed)));
        end
        w        = make_word(k_add, $random(stim_seed));
        w[14:5]  = 10'd0;
        send_item(k_add, w);
        idle_input();
        wait_drained();

        set_ready_mode(1);
        send_random(150);  // odd total so both pointers sit on lane one
        idle_input();
        wait_drained();

        // fill both lanes behind a stalled output and flush
        set_ready_mode(2);
        send_random(2);
        @(negedge clk);
        in_valid = 1'b0;
        flush    = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        assert (!out_valid && u_decode_top.u_dispatch.ptr == '0 &&
                u_decode_top.u_collect.ptr == '0)
            else abort_run("the flush left items in flight or did not reset the pointers");

        set_ready_mode(0);
        send_random(6);
        idle_input();
        wait_drained();

        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("decoded words were still outstanding at the end of the test");
        end
    end

endmodule

/* project.f */
source/decode_pkg.sv
source/inst_dispatch.sv
source/decode_lane.sv
source/reg_file.sv
source/decode_collect.sv
source/decode_top.sv
dv/decode_tb.sv

/* source/decode_collect.sv */
`timescale 1ns/100ps

module decode_collect #(
    parameter int lanes = decode_pkg::num_lanes_default
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic [lanes-1:0]              lane_valid,
    output logic [lanes-1:0]              lane_ready,
    input  decode_pkg::ctrl_t [lanes-1:0] lane_ctrl,
    output logic                          out_valid,
    input  logic                          out_ready,
    output decode_pkg::ctrl_t             out_ctrl
);
    localparam int ptr_w = (lanes > 1) ? $clog2(lanes) : 1;

    logic [ptr_w-1:0] ptr;  // lane holding the oldest item

    // same rotation as the dispatcher keeps program order
    assign out_valid = lane_valid[ptr];
    assign out_ctrl  = lane_ctrl[ptr];

    always_comb begin
        lane_ready      = '0;
        lane_ready[ptr] = out_ready;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ptr <= '0;
        end else if (out_valid && out_ready) begin
            ptr <= (ptr == ptr_w'(lanes - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

/* source/decode_lane.sv */
`timescale 1ns/100ps

module decode_lane (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               in_valid,
    output logic               in_ready,
    input  decode_pkg::fetch_t in_item,
    output logic [4:0]         rd1_index,
    output logic [4:0]         rd2_index,
    input  logic [31:0]        rd1_data,
    input  logic [31:0]        rd2_data,
    output logic               out_valid,
    input  logic               out_ready,
    output decode_pkg::ctrl_t  out_ctrl
);
    import decode_pkg::*;

    inst_u       iw;
    ctrl_t       dec;     // decode of the word on the input bus
    ctrl_t       ctrl_d;  // dec plus operand data
    logic        known;
    logic        accept;
    logic [31:0] imm12_s;
    logic [31:0] imm12_u;
    logic [31:0] imm20;
    logic [31:0] imm16;
    logic [31:0] imm26;
    logic [31:0] imm5;

    assign iw = in_item.inst;

    assign imm12_s = {{20{iw.ri12.imm12[11]}}, iw.ri12.imm12};
    assign imm12_u = {20'd0, iw.ri12.imm12};  // andi, ori, xori
    assign imm20   = {iw.ri20.imm20, 12'd0};
    assign imm16   = {{14{iw.ri16.offs16[15]}}, iw.ri16.offs16, 2'b00};
    assign imm26   = {{4{iw.i26.offs_25_16[9]}}, iw.i26.offs_25_16, iw.i26.offs_15_0, 2'b00};
    assign imm5    = {27'd0, iw.r3.rk};

    always_comb begin
        dec            = '0;
        dec.inst_valid = 1'b1;
        dec.wreg_en    = 1'b1;
        dec.wreg_index = iw.r3.rd;
        dec.rd1_index  = iw.r3.rj;
        dec.rd2_index  = iw.r3.rk;
        dec.pc         = in_item.pc;
        dec.inst       = iw;
        known          = 1'b1;

        case (iw.r3.opcode)
            17'h00020: dec.alu_op = alu_add;
            17'h00022: dec.alu_op = alu_sub;
            17'h00024: dec.alu_op = alu_slt;
            17'h00025: dec.alu_op = alu_sltu;
            17'h00028: dec.alu_op = alu_nor;
            17'h00029: dec.alu_op = alu_and;
            17'h0002a: dec.alu_op = alu_or;
            17'h0002b: dec.alu_op = alu_xor;
            17'h0002e: dec.alu_op = alu_sll;
            17'h0002f: dec.alu_op = alu_srl;
            17'h00030: dec.alu_op = alu_sra;
            17'h00081: dec.alu_op = alu_sll;  // slli
            17'h00089: dec.alu_op = alu_srl;  // srli
            17'h00091: dec.alu_op = alu_sra;  // srai
            17'h00054: begin                  // break
                dec.is_break = 1'b1;
                dec.wreg_en  = 1'b0;
            end
            default: known = 1'b0;
        endcase
        if (iw.r3.opcode inside {17'h00081, 17'h00089, 17'h00091}) begin
            dec.src2_sel = src_imm;
            dec.imm      = imm5;
        end

        // 12-bit alu immediates and memory
        if (!known) begin
            known        = 1'b1;
            dec.src2_sel = src_imm;
            dec.imm      = imm12_s;
            case (iw.ri12.opcode)
                10'h008: dec.alu_op = alu_slt;
                10'h009: dec.alu_op = alu_sltu;
                10'h00a: dec.alu_op = alu_add;
                10'h00d: begin
                    dec.alu_op = alu_and;
                    dec.imm    = imm12_u;
                end
                10'h00e: begin
                    dec.alu_op = alu_or;
                    dec.imm    = imm12_u;
                end
                10'h00f: begin
                    dec.alu_op = alu_xor;
                    dec.imm    = imm12_u;
                end
                10'h0a0: dec.mem_op = '{1'b1, 1'b0, mem_byte, 1'b0};  // ld.b
                10'h0a2: dec.mem_op = '{1'b1, 1'b0, mem_word, 1'b0};  // ld.w
                10'h0a4: dec.mem_op = '{1'b1, 1'b1, mem_byte, 1'b0};  // st.b
                10'h0a6: dec.mem_op = '{1'b1, 1'b1, mem_word, 1'b0};  // st.w
                10'h0a8: dec.mem_op = '{1'b1, 1'b0, mem_byte, 1'b1};  // ld.bu
                default: known = 1'b0;
            endcase
        end

        // branch targets are pc plus offset except for jirl
        if (!known) begin
            known        = 1'b1;
            dec.src1_sel = src_pc;
            dec.src2_sel = src_imm;
            dec.imm      = imm16;
            case (iw.ri16.opcode)
                6'h13: begin  // jirl
                    dec.branch_op = br_jirl;
                    dec.src1_sel  = src_reg;
                end
                6'h14: begin  // b
                    dec.branch_op = br_b;
                    dec.imm       = imm26;
                    dec.wreg_en   = 1'b0;
                end
                6'h15: begin  // bl links through r1
                    dec.branch_op  = br_b;
                    dec.imm        = imm26;
                    dec.wreg_index = 5'd1;
                end
                6'h16: dec.branch_op = br_beq;
                6'h17: dec.branch_op = br_bne;
                6'h18: dec.branch_op = br_blt;
                6'h19: dec.branch_op = br_bge;
                default: known = 1'b0;
            endcase
        end

        if (!known) begin
            known        = 1'b1;
            dec.src2_sel = src_imm;
            dec.imm      = imm20;
            case (iw.ri20.opcode)
                7'h0a: begin  // lu12i
                    dec.alu_op   = alu_lui;
                    dec.src1_sel = src_imm;
                end
                7'h0e: dec.src1_sel = src_pc;  // pcaddu12i
                default: known = 1'b0;
            endcase
        end

        // store data and branch compare operand come from rd
        if (dec.mem_op.is_store || dec.branch_op inside {br_beq, br_bne, br_blt, br_bge}) begin
            dec.rd2_index = iw.r3.rd;
            dec.wreg_en   = 1'b0;
        end

        if (!known) begin
            dec.inst_valid = 1'b0;
            dec.wreg_en    = 1'b0;
            dec.src1_sel   = src_reg;
            dec.src2_sel   = src_reg;
            dec.imm        = '0;
        end
    end

    assign rd1_index = dec.rd1_index;
    assign rd2_index = dec.rd2_index;

    always_comb begin
        ctrl_d          = dec;
        ctrl_d.rd1_data = rd1_data;
        ctrl_d.rd2_data = rd2_data;
    end

    // single slot that refills in the cycle it drains
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;  // a word arriving with flush is dropped too
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_ctrl <= ctrl_d;
        end
    end

endmodule

/* source/decode_pkg.sv */
package decode_pkg;

    localparam int num_lanes_default = 2;  // lanes instantiated by decode_top

    // register-register, shift-immediate and break
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;  // also ui5 for shift immediates
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;  // word offset
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm20;
        logic [4:0]  rd;
    } inst_1ri20_t;

    // b and bl keep the upper offset bits at the bottom of the word
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_15_0;
        logic [9:0]  offs_25_16;
    } inst_i26_t;

    typedef union packed {
        inst_3r_t    r3;
        inst_2ri12_t ri12;
        inst_2ri16_t ri16;
        inst_1ri20_t ri20;
        inst_i26_t   i26;
    } inst_u;

    typedef struct packed {
        logic [31:0] pc;
        inst_u       inst;
    } fetch_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
        alu_lui  // passes src2 through
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_jirl, br_b, br_beq, br_bne, br_blt, br_bge
    } branch_op_e;

    typedef enum logic {mem_byte, mem_word} mem_size_e;

    typedef struct packed {
        logic      is_mem;
        logic      is_store;
        mem_size_e size;
        logic      unsigned_ext;  // ld.bu
    } mem_op_t;

    typedef enum logic [1:0] {src_reg, src_imm, src_pc} src_sel_e;

    // bundle handed to the backend
    typedef struct packed {
        logic        inst_valid;
        logic        is_break;
        alu_op_e     alu_op;
        branch_op_e  branch_op;
        mem_op_t     mem_op;
        src_sel_e    src1_sel;
        src_sel_e    src2_sel;
        logic        wreg_en;
        logic [4:0]  wreg_index;
        logic [4:0]  rd1_index;
        logic [4:0]  rd2_index;
        logic [31:0] rd1_data;
        logic [31:0] rd2_data;
        logic [31:0] imm;
        logic [31:0] pc;
        inst_u       inst;
    } ctrl_t;

endpackage

/* source/decode_top.sv */
`timescale 1ns/100ps

module decode_top #(
    parameter int lanes = decode_pkg::num_lanes_default
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               in_valid,
    output logic               in_ready,
    input  decode_pkg::fetch_t in_item,
    output logic               out_valid,
    input  logic               out_ready,
    output decode_pkg::ctrl_t  out_ctrl,
    input  logic               wb_en,
    input  logic [4:0]         wb_index,
    input  logic [31:0]        wb_data
);
    import decode_pkg::*;

    logic [lanes-1:0]        lane_in_valid;
    logic [lanes-1:0]        lane_in_ready;
    fetch_t                  lane_item;
    logic [lanes-1:0][4:0]   rd1_index;
    logic [lanes-1:0][4:0]   rd2_index;
    logic [lanes-1:0][31:0]  rd1_data;
    logic [lanes-1:0][31:0]  rd2_data;
    logic [lanes-1:0]        lane_out_valid;
    logic [lanes-1:0]        lane_out_ready;
    ctrl_t [lanes-1:0]       lane_out_ctrl;

    inst_dispatch #(.lanes(lanes)) u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_item    (in_item),
        .lane_valid (lane_in_valid),
        .lane_ready (lane_in_ready),
        .lane_item  (lane_item)
    );

    reg_file #(.lanes(lanes)) u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd1_index (rd1_index),
        .rd2_index (rd2_index),
        .rd1_data  (rd1_data),
        .rd2_data  (rd2_data),
        .wb_en     (wb_en),
        .wb_index  (wb_index),
        .wb_data   (wb_data)
    );

    for (genvar k = 0; k < lanes; k++) begin : g_lane
        decode_lane u_lane (
            .clk       (clk),
            .reset     (reset),
            .flush     (flush),
            .in_valid  (lane_in_valid[k]),
            .in_ready  (lane_in_ready[k]),
            .in_item   (lane_item),
            .rd1_index (rd1_index[k]),
            .rd2_index (rd2_index[k]),
            .rd1_data  (rd1_data[k]),
            .rd2_data  (rd2_data[k]),
            .out_valid (lane_out_valid[k]),
            .out_ready (lane_out_ready[k]),
            .out_ctrl  (lane_out_ctrl[k])
        );
    end

    decode_collect #(.lanes(lanes)) u_collect (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .lane_valid (lane_out_valid),
        .lane_ready (lane_out_ready),
        .lane_ctrl  (lane_out_ctrl),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_ctrl   (out_ctrl)
    );

endmodule

/* source/inst_dispatch.sv */
`timescale 1ns/100ps

module inst_dispatch #(
    parameter int lanes = decode_pkg::num_lanes_default
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               in_valid,
    output logic               in_ready,
    input  decode_pkg::fetch_t in_item,
    output logic [lanes-1:0]   lane_valid,
    input  logic [lanes-1:0]   lane_ready,
    output decode_pkg::fetch_t lane_item
);
    localparam int ptr_w = (lanes > 1) ? $clog2(lanes) : 1;

    logic [ptr_w-1:0] ptr;  // lane that takes the next word

    // all lanes share the bus, only the pointed one sees valid
    assign lane_item = in_item;
    assign in_ready  = lane_ready[ptr];

    always_comb begin
        lane_valid      = '0;
        lane_valid[ptr] = in_valid;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ptr <= '0;
        end else if (in_valid && in_ready) begin
            ptr <= (ptr == ptr_w'(lanes - 1)) ? '0 : ptr + 1'b1;  // wrap after last lane
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
    parameter int lanes = decode_pkg::num_lanes_default
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [lanes-1:0][4:0]  rd1_index,
    input  logic [lanes-1:0][4:0]  rd2_index,
    output logic [lanes-1:0][31:0] rd1_data,
    output logic [lanes-1:0][31:0] rd2_data,
    input  logic                   wb_en,
    input  logic [4:0]             wb_index,
    input  logic [31:0]            wb_data
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_index != 5'd0) begin
            regs[wb_index] <= wb_data;
        end
    end

    // no write bypass, a same-cycle write shows up next cycle
    always_comb begin
        for (int k = 0; k < lanes; k++) begin
            rd1_data[k] = (rd1_index[k] == 5'd0) ? 32'd0 : regs[rd1_index[k]];
            rd2_data[k] = (rd2_index[k] == 5'd0) ? 32'd0 : regs[rd2_index[k]];
        end
    end

endmodule
